/* list.f */
+incdir+.
qspi_flash_pkg.sv
qspi_lane_rx.sv
qspi_cmd_fsm.sv
qspi_flash_array.sv
qspi_lane_tx.sv
qspi_flash_top.sv
tb_qspi_flash.sv

/* Bender.yml */
package:
  name: qspi_flash

sources:
  - files:
      - qspi_flash_pkg.sv
      - qspi_lane_rx.sv
      - qspi_cmd_fsm.sv
      - qspi_flash_array.sv
      - qspi_lane_tx.sv
      - qspi_flash_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_qspi_flash.sv

/* tb_qspi_tasks.svh */
// host side helpers for the qspi flash testbench
// frame and lane drivers, status polling, compare tasks and xorshift data
`ifndef TB_QSPI_TASKS_SVH
`define TB_QSPI_TASKS_SVH

function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

task automatic fill_random(input int n);
    for (int i = 0; i < n; i++) begin
        rng = xorshift(rng);
        exp_q.push_back(rng[7:0]);
    end
endtask

task automatic check_byte(input string name, input qspi_flash_pkg::data_byte_t got,
                          input qspi_flash_pkg::data_byte_t exp);
    if (got !== exp) begin
        errors++;
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_id(input qspi_flash_pkg::jedec_id_t got,
                        input qspi_flash_pkg::jedec_id_t exp);
    if (got !== exp) begin
        errors++;
        $display("mismatch at %0t: jedec_id got %h expected %h", $time, got, exp);
    end
endtask

// bit 0 is WIP, bit 1 is WEL
task automatic check_status(input qspi_flash_pkg::data_byte_t got,
                            input logic exp_wip, input logic exp_wel);
    if (got[0] !== exp_wip) begin
        errors++;
        $display("mismatch at %0t: status.wip got %b expected %b", $time, got[0], exp_wip);
    end
    if (got[1] !== exp_wel) begin
        errors++;
        $display("mismatch at %0t: status.wel got %b expected %b", $time, got[1], exp_wel);
    end
endtask

task automatic start_frame();
    @(posedge qspi_sclk);
    #10;
    qspi_cs_n = 1'b0;
endtask

task automatic end_frame();
    @(posedge qspi_sclk);
    #10;
    qspi_cs_n = 1'b1;
    @(posedge qspi_sclk);
    #10;
    drv_en  = 4'b1101;   // io1 stays free for the device
    drv_val = 4'b0000;
endtask

task automatic send_x1(input qspi_flash_pkg::data_byte_t b);
    for (int i = 7; i >= 0; i--) begin
        drv_val[0] = b[i];
        @(posedge qspi_sclk);
        #10;
    end
endtask

task automatic send_x4(input qspi_flash_pkg::data_byte_t b);
    drv_val = b[7:4];
    @(posedge qspi_sclk);
    #10;
    drv_val = b[3:0];
    @(posedge qspi_sclk);
    #10;
endtask

task automatic send_addr(input logic [23:0] addr);
    send_x1(addr[23:16]);
    send_x1(addr[15:8]);
    send_x1(addr[7:0]);
endtask

// output bits are taken at the falling edge, half a cycle after the device drives them
task automatic recv_x1(output qspi_flash_pkg::data_byte_t b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
        @(posedge qspi_sclk);
        @(negedge qspi_sclk);
        b = {b[6:0], qspi_io1};
    end
endtask

task automatic recv_x2(output qspi_flash_pkg::data_byte_t b);
    b = '0;
    for (int i = 0; i < 4; i++) begin
        @(posedge qspi_sclk);
        @(negedge qspi_sclk);
        b = {b[5:0], qspi_io1, qspi_io0};
    end
endtask

task automatic simple_cmd(input qspi_flash_pkg::opcode_e op);
    start_frame();
    send_x1(op);
    end_frame();
endtask

task automatic read_status(output qspi_flash_pkg::data_byte_t s);
    start_frame();
    send_x1(qspi_flash_pkg::OP_READ_STATUS);
    recv_x1(s);
    end_frame();
endtask

// programs exp_q from its first entry, 1-1-1 or 1-1-4
task automatic write_page(input qspi_flash_pkg::opcode_e op, input logic [23:0] addr);
    start_frame();
    send_x1(op);
    send_addr(addr);
    if (op == qspi_flash_pkg::OP_QUAD_PROG) begin
        drv_en = 4'b1111;
    end
    foreach (exp_q[i]) begin
        if (op == qspi_flash_pkg::OP_QUAD_PROG) begin
            send_x4(exp_q[i]);
        end else begin
            send_x1(exp_q[i]);
        end
    end
    end_frame();
endtask

task automatic erase_sector(input logic [23:0] addr);
    start_frame();
    send_x1(qspi_flash_pkg::OP_SECTOR_ERASE);
    send_addr(addr);
    end_frame();
endtask

// one status frame, streamed until WIP drops
task automatic poll_ready(output logic saw_busy);
    qspi_flash_pkg::data_byte_t s;
    int reads;
    saw_busy = 1'b0;
    reads    = 0;
    start_frame();
    send_x1(qspi_flash_pkg::OP_READ_STATUS);
    do begin
        recv_x1(s);
        reads++;
        if (s[0] === 1'b1) begin
            saw_busy = 1'b1;
        end
    end while (s[0] !== 1'b0 && reads < MAX_POLLS);
    end_frame();
    if (s[0] !== 1'b0) begin
        errors++;
        $display("error at %0t: the busy flag never cleared within %0d status reads",
                 $time, MAX_POLLS);
    end
endtask

task automatic wait_write_done(input string what);
    qspi_flash_pkg::data_byte_t s;
    logic saw_busy;
    poll_ready(saw_busy);
    if (!saw_busy) begin
        errors++;
        $display("error at %0t: %s never showed WIP in the status", $time, what);
    end
    read_status(s);
    check_status(s, 1'b0, 1'b0);   // WEL drops with busy
endtask

// compares n bytes against exp_q from entry first, or against the erased value
task automatic read_check(input qspi_flash_pkg::opcode_e op, input logic [23:0] addr,
                          input int first, input int n, input logic erased);
    qspi_flash_pkg::data_byte_t got;
    qspi_flash_pkg::data_byte_t exp;
    start_frame();
    send_x1(op);
    send_addr(addr);
    if (op == qspi_flash_pkg::OP_FAST_READ) begin
        repeat (FAST_DUMMY) @(posedge qspi_sclk);
    end else if (op == qspi_flash_pkg::OP_DUAL_READ) begin
        drv_en[0] = 1'b0;   // device drives io0 in x2 output
        repeat (DUAL_DUMMY) @(posedge qspi_sclk);
    end
    for (int i = 0; i < n; i++) begin
        if (op == qspi_flash_pkg::OP_DUAL_READ) begin
            recv_x2(got);
        end else begin
            recv_x1(got);
        end
        exp = erased ? 8'hFF : exp_q[first + i];
        check_byte($sformatf("rd_data[0x%05h]", addr + i), got, exp);
    end
    end_frame();
endtask

`endif

/* tb_qspi_flash.sv */
// testbench top for the qspi flash model
// clock, chip select reset, dut, timeout and the directed tests
`timescale 1ns/100ps
`default_nettype none

module tb_qspi_flash;

    localparam int MEM_BYTES      = 16384;
    localparam int BUSY_CYCLES    = 100;
    localparam int FAST_DUMMY     = 8;
    localparam int DUAL_DUMMY     = 4;
    localparam int MAX_POLLS      = 5000;
    localparam int TIMEOUT_CYCLES = 60000;   // about twice the erase plus all polls and frames

    logic        qspi_sclk;
    logic        qspi_cs_n;
    logic [3:0]  drv_en;    // host pin enables
    logic [3:0]  drv_val;
    wire         qspi_io0;
    wire         qspi_io1;
    wire         qspi_io2;
    wire         qspi_io3;
    int          errors;
    int          cycles;
    logic [31:0] rng;
    qspi_flash_pkg::data_byte_t exp_q [$];   // data of the latest program

    assign qspi_io0 = drv_en[0] ? drv_val[0] : 1'bz;
    assign qspi_io1 = drv_en[1] ? drv_val[1] : 1'bz;
    assign qspi_io2 = drv_en[2] ? drv_val[2] : 1'bz;
    assign qspi_io3 = drv_en[3] ? drv_val[3] : 1'bz;

    qspi_flash_top #(
        .MEM_BYTES   (MEM_BYTES),
        .BUSY_CYCLES (BUSY_CYCLES)
    ) i_dut (
        .qspi_sclk (qspi_sclk),
        .qspi_cs_n (qspi_cs_n),
        .qspi_io0  (qspi_io0),
        .qspi_io1  (qspi_io1),
        .qspi_io2  (qspi_io2),
        .qspi_io3  (qspi_io3)
    );

    initial begin
        qspi_sclk = 1'b0;
        forever #50 qspi_sclk = ~qspi_sclk;
    end

    initial cycles = 0;

    always @(posedge qspi_sclk) begin
        cycles++;
        if (cycles == TIMEOUT_CYCLES) begin
            errors++;
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests done with %0d errors", errors);
            $display(">>> FAIL");
            $finish;
        end
    end

    `include "tb_qspi_tasks.svh"

    task automatic jedec_id_read();
        qspi_flash_pkg::data_byte_t b [3];
        start_frame();
        send_x1(qspi_flash_pkg::OP_READ_ID);
        for (int i = 0; i < 3; i++) begin
            recv_x1(b[i]);
        end
        end_frame();
        check_id({b[0], b[1], b[2]}, 24'hC22017);
    endtask

    task automatic write_enable_latch();
        qspi_flash_pkg::data_byte_t s;
        read_status(s);
        check_status(s, 1'b0, 1'b0);
        simple_cmd(qspi_flash_pkg::OP_WREN);
        read_status(s);
        check_status(s, 1'b0, 1'b1);
        simple_cmd(qspi_flash_pkg::OP_WRDI);
        read_status(s);
        check_status(s, 1'b0, 1'b0);
    endtask

    task automatic page_program_flow();
        qspi_flash_pkg::data_byte_t s;
        exp_q.delete();
        fill_random(4);
        write_page(qspi_flash_pkg::OP_PAGE_PROG, 24'h001010);   // dropped while WEL is 0
        read_check(qspi_flash_pkg::OP_READ, 24'h001010, 0, 4, 1'b1);
        read_status(s);
        check_status(s, 1'b0, 1'b0);

        simple_cmd(qspi_flash_pkg::OP_WREN);
        exp_q.delete();
        fill_random(32);   // 16 bytes run past the page end
        write_page(qspi_flash_pkg::OP_PAGE_PROG, 24'h0010F0);
        wait_write_done("page program");
        read_check(qspi_flash_pkg::OP_READ, 24'h0010F0, 0, 16, 1'b0);
        read_check(qspi_flash_pkg::OP_READ, 24'h001000, 16, 16, 1'b0);
        read_check(qspi_flash_pkg::OP_READ, 24'h001100, 0, 1, 1'b1);
    endtask

    task automatic quad_program_reads();
        simple_cmd(qspi_flash_pkg::OP_WREN);
        exp_q.delete();
        fill_random(16);
        write_page(qspi_flash_pkg::OP_QUAD_PROG, 24'h002040);
        wait_write_done("quad program");
        read_check(qspi_flash_pkg::OP_FAST_READ, 24'h002040, 0, 16, 1'b0);
        read_check(qspi_flash_pkg::OP_DUAL_READ, 24'h002040, 0, 16, 1'b0);
    endtask

    task automatic sector_erase_flow();
        // data at the end of the erased sector that wraps to 0x2F00
        simple_cmd(qspi_flash_pkg::OP_WREN);
        exp_q.delete();
        fill_random(8);
        write_page(qspi_flash_pkg::OP_PAGE_PROG, 24'h002FFC);
        wait_write_done("program of the sector end");

        // data in the sector after the erased one
        simple_cmd(qspi_flash_pkg::OP_WREN);
        exp_q.delete();
        fill_random(8);
        write_page(qspi_flash_pkg::OP_PAGE_PROG, 24'h003000);
        wait_write_done("program of the next sector");

        simple_cmd(qspi_flash_pkg::OP_WREN);
        erase_sector(24'h002123);
        wait_write_done("sector erase");
        read_check(qspi_flash_pkg::OP_READ, 24'h002F00, 0, 4, 1'b1);
        read_check(qspi_flash_pkg::OP_FAST_READ, 24'h002040, 0, 16, 1'b1);
        read_check(qspi_flash_pkg::OP_READ, 24'h002FFC, 0, 4, 1'b1);
        read_check(qspi_flash_pkg::OP_READ, 24'h003000, 0, 8, 1'b0);
    endtask

    initial begin
        qspi_cs_n = 1'b1;
        drv_en    = 4'b1101;
        drv_val   = 4'b0000;
        errors    = 0;
        rng       = 32'd44;
        repeat (10) @(posedge qspi_sclk);

        jedec_id_read();
        write_enable_latch();
        page_program_flow();
        quad_program_reads();
        sector_erase_flow();

        $display("tests done with %0d errors", errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* qspi_flash_top.sv */
// top level of the qspi flash model
// joins the io pins and wires the receiver, fsm, array and transmitter
`timescale 1ns/100ps
`default_nettype none

module qspi_flash_top #(
    parameter int MEM_BYTES   = 16384,
    parameter int BUSY_CYCLES = 100
) (
    input wire qspi_sclk,
    input wire qspi_cs_n,
    inout wire qspi_io0,
    inout wire qspi_io1,
    inout wire qspi_io2,
    inout wire qspi_io3
);

    localparam int AW = $clog2(MEM_BYTES);

    logic [3:0] io_in;
    logic [3:0] io_out;
    logic [3:0] io_en;
    logic [3:0] tx_oe;

    qspi_flash_pkg::lane_mode_e lanes;
    qspi_flash_pkg::lane_mode_e tx_lanes;
    qspi_flash_pkg::data_byte_t rx_byte;
    qspi_flash_pkg::data_byte_t rd_data;
    qspi_flash_pkg::data_byte_t wr_data;
    qspi_flash_pkg::data_byte_t tx_byte;

    logic          rx_valid;
    logic          wr_en;
    logic          erase_start;
    logic          busy;
    logic          busy_done;
    logic          tx_load;
    logic          tx_byte_done;
    logic [AW-1:0] wr_addr;
    logic [AW-1:0] erase_addr;
    logic [AW-1:0] rd_addr;

    assign io_in = {qspi_io3, qspi_io2, qspi_io1, qspi_io0};

    // tri-state pads
    assign qspi_io0 = io_en[0] ? io_out[0] : 1'bz;
    assign qspi_io1 = io_en[1] ? io_out[1] : 1'bz;
    assign qspi_io2 = io_en[2] ? io_out[2] : 1'bz;
    assign qspi_io3 = io_en[3] ? io_out[3] : 1'bz;

    qspi_lane_rx u_rx (
        .qspi_sclk (qspi_sclk),
        .qspi_cs_n (qspi_cs_n),
        .io_in     (io_in),
        .lanes     (lanes),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid)
    );

    qspi_cmd_fsm #(
        .MEM_BYTES (MEM_BYTES)
    ) u_fsm (
        .qspi_sclk    (qspi_sclk),
        .qspi_cs_n    (qspi_cs_n),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid),
        .rd_data      (rd_data),
        .busy         (busy),
        .busy_done    (busy_done),
        .tx_byte_done (tx_byte_done),
        .lanes        (lanes),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .erase_start  (erase_start),
        .erase_addr   (erase_addr),
        .rd_addr      (rd_addr),
        .tx_load      (tx_load),
        .tx_byte      (tx_byte),
        .tx_lanes     (tx_lanes),
        .tx_oe        (tx_oe)
    );

    qspi_flash_array #(
        .MEM_BYTES   (MEM_BYTES),
        .BUSY_CYCLES (BUSY_CYCLES)
    ) u_array (
        .qspi_sclk   (qspi_sclk),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .erase_start (erase_start),
        .erase_addr  (erase_addr),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .busy        (busy),
        .busy_done   (busy_done)
    );

    qspi_lane_tx u_tx (
        .qspi_sclk    (qspi_sclk),
        .qspi_cs_n    (qspi_cs_n),
        .tx_load      (tx_load),
        .tx_byte      (tx_byte),
        .tx_lanes     (tx_lanes),
        .tx_oe        (tx_oe),
        .tx_byte_done (tx_byte_done),
        .io_out       (io_out),
        .io_en        (io_en)
    );

endmodule

`default_nettype wire

/* qspi_lane_tx.sv */
// output serializer for the qspi pins
// shifts bytes msb first on io1 or io1:io0 and reloads after each byte
`timescale 1ns/100ps
`default_nettype none

module qspi_lane_tx (
    input  logic                       qspi_sclk,
    input  logic                       qspi_cs_n,
    input  logic                       tx_load,
    input  qspi_flash_pkg::data_byte_t tx_byte,
    input  qspi_flash_pkg::lane_mode_e tx_lanes,
    input  logic [3:0]                 tx_oe,
    output logic                       tx_byte_done,
    output logic [3:0]                 io_out,
    output logic [3:0]                 io_en
);

    qspi_flash_pkg::data_byte_t shift_q;
    qspi_flash_pkg::lane_mode_e lanes_q;
    logic [2:0] cnt_q;   // groups already shifted in this byte
    logic [2:0] last_cnt;
    logic [3:0] en_q;
    logic       reload;

    always_comb begin
        case (lanes_q)
            qspi_flash_pkg::LANE_X2: begin
                last_cnt = 3'd3;
                io_out   = {2'b00, shift_q[7:6]};
            end
            qspi_flash_pkg::LANE_X4: begin
                last_cnt = 3'd1;
                io_out   = shift_q[7:4];
            end
            default: begin
                last_cnt = 3'd7;
                io_out   = {2'b00, shift_q[7], 1'b0};   // SO is io1
            end
        endcase
    end

    assign tx_byte_done = (|en_q) && (cnt_q == last_cnt);
    assign reload       = tx_load || tx_byte_done;
    assign io_en        = en_q;

    always_ff @(posedge qspi_sclk or posedge qspi_cs_n) begin
        if (qspi_cs_n) begin
            cnt_q   <= '0;
            lanes_q <= qspi_flash_pkg::LANE_X1;
            en_q    <= 4'b0000;   // all pins float
        end else begin
            cnt_q <= reload ? 3'd0 : cnt_q + 3'd1;
            if (tx_load) begin
                lanes_q <= tx_lanes;
                en_q    <= tx_oe;
            end
        end
    end

    always_ff @(posedge qspi_sclk) begin
        if (reload) begin
            shift_q <= tx_byte;
        end else begin
            case (lanes_q)
                qspi_flash_pkg::LANE_X2: shift_q <= shift_q << 2;
                qspi_flash_pkg::LANE_X4: shift_q <= shift_q << 4;
                default:                 shift_q <= shift_q << 1;
            endcase
        end
    end

endmodule

`default_nettype wire

/* qspi_flash_array.sv */
// byte array of the flash model
// page writes, the sector erase walker and the program busy timer
`timescale 1ns/100ps
`default_nettype none

module qspi_flash_array #(
    parameter int MEM_BYTES   = 16384,
    parameter int BUSY_CYCLES = 100
) (
    input  logic                         qspi_sclk,
    input  logic                         wr_en,
    input  logic [$clog2(MEM_BYTES)-1:0] wr_addr,
    input  qspi_flash_pkg::data_byte_t   wr_data,
    input  logic                         erase_start,
    input  logic [$clog2(MEM_BYTES)-1:0] erase_addr,
    input  logic [$clog2(MEM_BYTES)-1:0] rd_addr,
    output qspi_flash_pkg::data_byte_t   rd_data,
    output logic                         busy,
    output logic                         busy_done
);

    localparam int AW = $clog2(MEM_BYTES);
    localparam int SW = $clog2(qspi_flash_pkg::SECTOR_BYTES);
    localparam int CW = $clog2(BUSY_CYCLES + 1);

    // erased flash reads as all ones
    qspi_flash_pkg::data_byte_t mem [MEM_BYTES] = '{default: 8'hFF};

    logic          erase_active = 1'b0;
    logic [AW-1:0] erase_ptr    = '0;
    logic [CW-1:0] prog_cnt     = '0;   // edges left until program busy ends
    logic          busy_q       = 1'b0;

    assign rd_data = mem[rd_addr];

    always_ff @(posedge qspi_sclk) begin
        if (erase_active) begin
            mem[erase_ptr] <= 8'hFF;   // one byte per edge
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // sector walker
    always_ff @(posedge qspi_sclk) begin
        if (erase_active) begin
            erase_ptr <= erase_ptr + 1'b1;
            if (&erase_ptr[SW-1:0]) begin
                erase_active <= 1'b0;   // last byte of the sector
            end
        end else if (erase_start) begin
            erase_ptr    <= {erase_addr[AW-1:SW], SW'(0)};
            erase_active <= 1'b1;
        end
    end

    // program busy restarts on every written byte
    always_ff @(posedge qspi_sclk) begin
        if (wr_en) begin
            prog_cnt <= CW'(BUSY_CYCLES);
        end else if (prog_cnt != '0) begin
            prog_cnt <= prog_cnt - 1'b1;
        end
        busy_q <= busy;
    end

    assign busy      = erase_active || (prog_cnt != '0);
    assign busy_done = busy_q && !busy;   // falling edge of busy

endmodule

`default_nettype wire

/* qspi_cmd_fsm.sv */
// command decoder and phase sequencer of the flash model
// holds WEL, builds the status byte and picks the byte to shift out
`timescale 1ns/100ps
`default_nettype none

module qspi_cmd_fsm #(
    parameter int MEM_BYTES = 16384
) (
    input  logic                         qspi_sclk,
    input  logic                         qspi_cs_n,
    input  qspi_flash_pkg::data_byte_t   rx_byte,
    input  logic                         rx_valid,
    input  qspi_flash_pkg::data_byte_t   rd_data,
    input  logic                         busy,
    input  logic                         busy_done,
    input  logic                         tx_byte_done,
    output qspi_flash_pkg::lane_mode_e   lanes,
    output logic                         wr_en,
    output logic [$clog2(MEM_BYTES)-1:0] wr_addr,
    output qspi_flash_pkg::data_byte_t   wr_data,
    output logic                         erase_start,
    output logic [$clog2(MEM_BYTES)-1:0] erase_addr,
    output logic [$clog2(MEM_BYTES)-1:0] rd_addr,
    output logic                         tx_load,
    output qspi_flash_pkg::data_byte_t   tx_byte,
    output qspi_flash_pkg::lane_mode_e   tx_lanes,
    output logic [3:0]                   tx_oe
);

    localparam int AW = $clog2(MEM_BYTES);
    localparam int PW = $clog2(qspi_flash_pkg::PAGE_BYTES);

    qspi_flash_pkg::phase_e  phase_q;
    qspi_flash_pkg::opcode_e cmd_q;
    logic [1:0]    addr_cnt_q;
    logic [3:0]    dummy_cnt_q;
    logic [3:0]    dummy_last;
    logic [AW-1:0] addr_q;
    logic [1:0]    id_idx_q;
    logic          addr_done;
    logic [7:0]    status;
    logic          wel = 1'b0;   // survives chip select

    assign addr_done = (phase_q == qspi_flash_pkg::PH_ADDR) && rx_valid &&
                       (addr_cnt_q == 2'(qspi_flash_pkg::ADDR_BYTES - 1));

    assign dummy_last = (cmd_q == qspi_flash_pkg::OP_DUAL_READ) ?
                        4'(qspi_flash_pkg::DUAL_READ_DUMMY - 1) :
                        4'(qspi_flash_pkg::FAST_READ_DUMMY - 1);

    // memory side strobes, taken on the edge that completes the byte
    assign wr_en       = (phase_q == qspi_flash_pkg::PH_WRITE) && rx_valid;
    assign wr_addr     = addr_q;
    assign wr_data     = rx_byte;
    assign erase_start = addr_done && (cmd_q == qspi_flash_pkg::OP_SECTOR_ERASE);
    assign erase_addr  = {addr_q[AW-9:0], rx_byte};
    assign rd_addr     = addr_q;

    always_comb begin
        status = '0;
        status[qspi_flash_pkg::STATUS_WIP_BIT] = busy;
        status[qspi_flash_pkg::STATUS_WEL_BIT] = wel;
    end

    // next byte for the serializer
    always_comb begin
        case (phase_q)
            qspi_flash_pkg::PH_STATUS: tx_byte = status;   // live value on every reload
            qspi_flash_pkg::PH_ID: begin
                case (id_idx_q)
                    2'd0:    tx_byte = qspi_flash_pkg::JEDEC_ID[23:16];
                    2'd1:    tx_byte = qspi_flash_pkg::JEDEC_ID[15:8];
                    default: tx_byte = qspi_flash_pkg::JEDEC_ID[7:0];
                endcase
            end
            default: tx_byte = rd_data;
        endcase
    end

    // write enable latch, cleared when a program or erase completes
    always_ff @(posedge qspi_sclk) begin
        if (busy_done) begin
            wel <= 1'b0;
        end else if (phase_q == qspi_flash_pkg::PH_CMD && rx_valid) begin
            if (rx_byte == qspi_flash_pkg::OP_WREN) begin
                wel <= 1'b1;
            end else if (rx_byte == qspi_flash_pkg::OP_WRDI) begin
                wel <= 1'b0;
            end
        end
    end

    always_ff @(posedge qspi_sclk or posedge qspi_cs_n) begin
        if (qspi_cs_n) begin
            phase_q     <= qspi_flash_pkg::PH_CMD;
            cmd_q       <= qspi_flash_pkg::OP_READ;
            addr_cnt_q  <= '0;
            dummy_cnt_q <= '0;
            addr_q      <= '0;
            id_idx_q    <= '0;
            lanes       <= qspi_flash_pkg::LANE_X1;
            tx_load     <= 1'b0;
            tx_lanes    <= qspi_flash_pkg::LANE_X1;
            tx_oe       <= 4'b0000;
        end else begin
            tx_load <= 1'b0;
            case (phase_q)
                qspi_flash_pkg::PH_CMD: begin
                    if (rx_valid) begin
                        cmd_q <= qspi_flash_pkg::opcode_e'(rx_byte);
                        case (qspi_flash_pkg::opcode_e'(rx_byte))
                            qspi_flash_pkg::OP_READ_ID: begin
                                phase_q  <= qspi_flash_pkg::PH_ID;
                                id_idx_q <= 2'd0;
                                tx_load  <= 1'b1;
                                tx_lanes <= qspi_flash_pkg::LANE_X1;
                                tx_oe    <= 4'b0010;   // SO on io1
                            end
                            qspi_flash_pkg::OP_READ_STATUS: begin
                                phase_q  <= qspi_flash_pkg::PH_STATUS;
                                tx_load  <= 1'b1;
                                tx_lanes <= qspi_flash_pkg::LANE_X1;
                                tx_oe    <= 4'b0010;
                            end
                            qspi_flash_pkg::OP_READ,
                            qspi_flash_pkg::OP_FAST_READ,
                            qspi_flash_pkg::OP_DUAL_READ: phase_q <= qspi_flash_pkg::PH_ADDR;
                            qspi_flash_pkg::OP_PAGE_PROG,
                            qspi_flash_pkg::OP_QUAD_PROG,
                            qspi_flash_pkg::OP_SECTOR_ERASE: begin
                                phase_q <= wel ? qspi_flash_pkg::PH_ADDR :
                                                 qspi_flash_pkg::PH_IGNORE;
                            end
                            default: phase_q <= qspi_flash_pkg::PH_IGNORE;   // WREN, WRDI, unknown
                        endcase
                    end
                end
                qspi_flash_pkg::PH_ADDR: begin
                    if (rx_valid) begin
                        addr_q     <= {addr_q[AW-9:0], rx_byte};   // high address bits drop off
                        addr_cnt_q <= addr_cnt_q + 2'd1;
                    end
                    if (addr_done) begin
                        dummy_cnt_q <= '0;
                        case (cmd_q)
                            qspi_flash_pkg::OP_READ: begin
                                phase_q  <= qspi_flash_pkg::PH_READ;
                                tx_load  <= 1'b1;
                                tx_lanes <= qspi_flash_pkg::LANE_X1;
                                tx_oe    <= 4'b0010;
                            end
                            qspi_flash_pkg::OP_FAST_READ,
                            qspi_flash_pkg::OP_DUAL_READ: phase_q <= qspi_flash_pkg::PH_DUMMY;
                            qspi_flash_pkg::OP_PAGE_PROG: phase_q <= qspi_flash_pkg::PH_WRITE;
                            qspi_flash_pkg::OP_QUAD_PROG: begin
                                phase_q <= qspi_flash_pkg::PH_WRITE;
                                lanes   <= qspi_flash_pkg::LANE_X4;   // 1-1-4 data
                            end
                            default: phase_q <= qspi_flash_pkg::PH_IGNORE;   // erase already started
                        endcase
                    end
                end
                qspi_flash_pkg::PH_DUMMY: begin
                    dummy_cnt_q <= dummy_cnt_q + 4'd1;
                    if (dummy_cnt_q == dummy_last) begin
                        phase_q <= qspi_flash_pkg::PH_READ;
                        tx_load <= 1'b1;
                        if (cmd_q == qspi_flash_pkg::OP_DUAL_READ) begin
                            tx_lanes <= qspi_flash_pkg::LANE_X2;
                            tx_oe    <= 4'b0011;
                        end else begin
                            tx_lanes <= qspi_flash_pkg::LANE_X1;
                            tx_oe    <= 4'b0010;
                        end
                    end
                end
                qspi_flash_pkg::PH_READ: begin
                    if (tx_load || tx_byte_done) begin
                        addr_q <= addr_q + 1'b1;   // keep tx_byte one ahead
                    end
                end
                qspi_flash_pkg::PH_WRITE: begin
                    if (rx_valid) begin
                        // wrap inside the page
                        addr_q <= {addr_q[AW-1:PW], addr_q[PW-1:0] + PW'(1)};
                    end
                end
                qspi_flash_pkg::PH_ID: begin
                    if (tx_load || tx_byte_done) begin
                        id_idx_q <= (id_idx_q == 2'd2) ? 2'd0 : id_idx_q + 2'd1;
                    end
                end
                default: ;   // status streams by itself, ignore waits for cs
            endcase
        end
    end

endmodule

`default_nettype wire

/* qspi_lane_rx.sv */
// input deserializer for the qspi pins
// assembles x1, x2 or x4 groups into bytes, msb first
`timescale 1ns/100ps
`default_nettype none

module qspi_lane_rx (
    input  logic                       qspi_sclk,
    input  logic                       qspi_cs_n,
    input  logic [3:0]                 io_in,
    input  qspi_flash_pkg::lane_mode_e lanes,
    output qspi_flash_pkg::data_byte_t rx_byte,
    output logic                       rx_valid
);

    qspi_flash_pkg::data_byte_t shift_q;
    qspi_flash_pkg::data_byte_t shift_next;
    logic [2:0] cnt_q;        // bits collected so far
    logic [3:0] cnt_next;
    logic [3:0] step;

    always_comb begin
        case (lanes)
            qspi_flash_pkg::LANE_X2: begin
                step       = 4'd2;
                shift_next = {shift_q[5:0], io_in[1:0]};
            end
            qspi_flash_pkg::LANE_X4: begin
                step       = 4'd4;
                shift_next = {shift_q[3:0], io_in};
            end
            default: begin
                step       = 4'd1;
                shift_next = {shift_q[6:0], io_in[0]};   // single lane on io0
            end
        endcase
    end

    assign cnt_next = {1'b0, cnt_q} + step;

    // the sampling edge at the end of this cycle completes the byte
    assign rx_valid = cnt_next[3];
    assign rx_byte  = shift_next;

    always_ff @(posedge qspi_sclk or posedge qspi_cs_n) begin
        if (qspi_cs_n) begin
            shift_q <= '0;
            cnt_q   <= '0;
        end else begin
            shift_q <= shift_next;
            cnt_q   <= cnt_next[2:0];   // rolls over into the next byte
        end
    end

endmodule

`default_nettype wire

/* qspi_flash_pkg.sv */
// shared types and constants for the qspi flash model
// opcodes, protocol phases, lane modes, id and timing constants
`default_nettype none

package qspi_flash_pkg;

    // kept command set
    typedef enum logic [7:0] {
        OP_READ_ID      = 8'h9F,
        OP_READ_STATUS  = 8'h05,
        OP_WREN         = 8'h06,
        OP_WRDI         = 8'h04,
        OP_READ         = 8'h03,
        OP_FAST_READ    = 8'h0B,
        OP_DUAL_READ    = 8'h3B,
        OP_PAGE_PROG    = 8'h02,
        OP_QUAD_PROG    = 8'h32,
        OP_SECTOR_ERASE = 8'h20
    } opcode_e;

    typedef enum logic [2:0] {
        PH_CMD,
        PH_ADDR,
        PH_DUMMY,
        PH_READ,
        PH_WRITE,
        PH_STATUS,
        PH_ID,
        PH_IGNORE   // rest of the frame is dropped
    } phase_e;

    typedef enum logic [1:0] {
        LANE_X1 = 2'd0,
        LANE_X2 = 2'd1,
        LANE_X4 = 2'd2
    } lane_mode_e;

    typedef logic [7:0]  data_byte_t;
    typedef logic [23:0] jedec_id_t;

    localparam jedec_id_t JEDEC_ID = 24'hC22017;   // manufacturer, type, capacity

    localparam int ADDR_BYTES   = 3;
    localparam int PAGE_BYTES   = 256;
    localparam int SECTOR_BYTES = 4096;

    // dummy edges between address and read data
    localparam int FAST_READ_DUMMY = 8;
    localparam int DUAL_READ_DUMMY = 4;

    localparam int STATUS_WIP_BIT = 0;
    localparam int STATUS_WEL_BIT = 1;

endpackage

`default_nettype wire
